/* rtl/riscv_macros.svh */
`ifndef RISCV_MACROS_SVH
`define RISCV_MACROS_SVH

// operand a select.
`define OP_A_RS1        2'd0
`define OP_A_CURR_PC    2'd1
`define OP_A_ZERO       2'd2

// operand b select.
`define OP_B_RS2        3'd0
`define OP_B_IMM_I      3'd1
`define OP_B_IMM_U      3'd2
`define OP_B_IMM_S      3'd3
`define OP_B_INCR       3'd4

// upper two bits of the alu operation pick the group.
`define ALU_ADD         5'b00000
`define ALU_SLL         5'b00001
`define ALU_SLTS        5'b00010
`define ALU_SLTU        5'b00011
`define ALU_XOR         5'b00100
`define ALU_SRL         5'b00101
`define ALU_OR          5'b00110
`define ALU_AND         5'b00111
`define ALU_SUB         5'b01000
`define ALU_SRA         5'b01101
`define ALU_EQ          5'b11000
`define ALU_NE          5'b11001
`define ALU_LTS         5'b11100
`define ALU_GES         5'b11101
`define ALU_LTU         5'b11110
`define ALU_GEU         5'b11111

// load/store sizes use the funct3 coding.
`define LDST_B          3'b000
`define LDST_H          3'b001
`define LDST_W          3'b010
`define LDST_BU         3'b100
`define LDST_HU         3'b101

`define WB_EX_RESULT    1'b0
`define WB_LSU_DATA     1'b1

`define JALR_NONE       2'd0
`define JALR_ALU        2'd1
`define JALR_MEPC       2'd2
`define JALR_MTVEC      2'd3

// opcode[6:2].
`define LOAD_OPCODE     5'b00000
`define MISC_MEM_OPCODE 5'b00011
`define OP_IMM_OPCODE   5'b00100
`define AUIPC_OPCODE    5'b00101
`define STORE_OPCODE    5'b01000
`define OP_OPCODE       5'b01100
`define LUI_OPCODE      5'b01101
`define BRANCH_OPCODE   5'b11000
`define JALR_OPCODE     5'b11001
`define JAL_OPCODE      5'b11011
`define SYSTEM_OPCODE   5'b11100

`define CSR_MSTATUS     12'h300
`define CSR_MIE         12'h304
`define CSR_MTVEC       12'h305
`define CSR_MSCRATCH    12'h340
`define CSR_MEPC        12'h341
`define CSR_MCAUSE      12'h342

`endif

/* rtl/riscv_pkg.sv */
package riscv_pkg;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // one fetched word, seen through each format.
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } instr_u;

  typedef struct packed {
    logic [1:0] ex_op_a_sel;
    logic [2:0] ex_op_b_sel;
    logic [4:0] alu_op;
    logic       gpr_we;
    logic       wb_src_sel;
    logic       branch;
    logic       jal;
    logic [1:0] jalr;
    logic       csr;
    logic [2:0] csr_op;    // bit 2 is trap entry.
    logic       int_rst;
    logic       illegal;
  } ctrl_t;

  typedef struct packed {
    logic       req;
    logic       we;
    logic [2:0] size;
  } mem_req_t;

endpackage

/* rtl/decoder_riscv.sv */
`timescale 1ns/100ps
`include "riscv_macros.svh"

module decoder_riscv (
  input  riscv_pkg::instr_u   fetched_instr_i,
  input  logic                lsu_stall_req_i,
  input  logic                int_i,
  output riscv_pkg::ctrl_t    ctrl_o,
  output riscv_pkg::mem_req_t mem_o,
  output logic                enpc_o
);
  localparam logic [6:0]  FUNCT7_STD   = 7'b0000000;
  localparam logic [6:0]  FUNCT7_ALT   = 7'b0100000;
  localparam logic [11:0] MRET_FUNCT12 = 12'h302;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = fetched_instr_i.r.opcode;
  assign funct3 = fetched_instr_i.r.funct3;
  assign funct7 = fetched_instr_i.r.funct7;

  assign enpc_o = !lsu_stall_req_i;

  always_comb begin
    ctrl_o             = '0;
    ctrl_o.ex_op_a_sel = `OP_A_RS1;
    ctrl_o.ex_op_b_sel = `OP_B_IMM_I;
    ctrl_o.alu_op      = `ALU_ADD;
    ctrl_o.wb_src_sel  = `WB_EX_RESULT;
    ctrl_o.jalr        = `JALR_NONE;
    mem_o              = '0;
    mem_o.size         = `LDST_B;

    case (opcode)
      {`LOAD_OPCODE, 2'b11}: begin
        mem_o.req         = 1'b1;
        mem_o.size        = funct3;
        ctrl_o.gpr_we     = 1'b1;
        ctrl_o.wb_src_sel = `WB_LSU_DATA;
        if (funct3 inside {3'b011, 3'b110, 3'b111})
          ctrl_o.illegal = 1'b1;
      end

      {`MISC_MEM_OPCODE, 2'b11}: begin
        ctrl_o.illegal = (funct3 != 3'b000);  // fence does nothing here.
      end

      {`OP_IMM_OPCODE, 2'b11}: begin
        ctrl_o.alu_op = {2'b00, funct3};
        ctrl_o.gpr_we = 1'b1;
        if (funct3 == 3'b101 && funct7 == FUNCT7_ALT)
          ctrl_o.alu_op = `ALU_SRA;
        if (funct3 == 3'b001 && funct7 != FUNCT7_STD)
          ctrl_o.illegal = 1'b1;
        if (funct3 == 3'b101 && funct7 != FUNCT7_STD && funct7 != FUNCT7_ALT)
          ctrl_o.illegal = 1'b1;
      end

      {`AUIPC_OPCODE, 2'b11}: begin
        ctrl_o.ex_op_a_sel = `OP_A_CURR_PC;
        ctrl_o.ex_op_b_sel = `OP_B_IMM_U;
        ctrl_o.gpr_we      = 1'b1;
      end

      {`STORE_OPCODE, 2'b11}: begin
        ctrl_o.ex_op_b_sel = `OP_B_IMM_S;
        mem_o.req          = 1'b1;
        mem_o.we           = 1'b1;
        mem_o.size         = funct3;
        if (funct3 != `LDST_B && funct3 != `LDST_H && funct3 != `LDST_W)
          ctrl_o.illegal = 1'b1;
      end

      {`OP_OPCODE, 2'b11}: begin
        ctrl_o.ex_op_b_sel = `OP_B_RS2;
        ctrl_o.alu_op      = {2'b00, funct3};
        ctrl_o.gpr_we      = 1'b1;
        if (funct7 == FUNCT7_ALT) begin
          ctrl_o.alu_op  = {2'b01, funct3};
          ctrl_o.illegal = (funct3 != 3'b000 && funct3 != 3'b101);
        end else if (funct7 != FUNCT7_STD) begin
          ctrl_o.illegal = 1'b1;
        end
      end

      {`LUI_OPCODE, 2'b11}: begin
        ctrl_o.ex_op_a_sel = `OP_A_ZERO;
        ctrl_o.ex_op_b_sel = `OP_B_IMM_U;
        ctrl_o.gpr_we      = 1'b1;
      end

      {`BRANCH_OPCODE, 2'b11}: begin
        ctrl_o.ex_op_b_sel = `OP_B_RS2;
        ctrl_o.alu_op      = {2'b11, funct3};
        ctrl_o.branch      = 1'b1;
        if (funct3 == 3'b010 || funct3 == 3'b011) begin
          ctrl_o.alu_op  = `ALU_EQ;
          ctrl_o.illegal = 1'b1;
        end
      end

      {`JALR_OPCODE, 2'b11}: begin
        ctrl_o.ex_op_a_sel = `OP_A_CURR_PC;  // link value.
        ctrl_o.ex_op_b_sel = `OP_B_INCR;
        ctrl_o.gpr_we      = 1'b1;
        ctrl_o.jalr        = `JALR_ALU;
        ctrl_o.illegal     = (funct3 != 3'b000);
      end

      {`JAL_OPCODE, 2'b11}: begin
        ctrl_o.ex_op_a_sel = `OP_A_CURR_PC;
        ctrl_o.ex_op_b_sel = `OP_B_INCR;
        ctrl_o.gpr_we      = 1'b1;
        ctrl_o.jal         = 1'b1;
      end

      {`SYSTEM_OPCODE, 2'b11}: begin
        case (funct3)
          3'b000: begin
            if (fetched_instr_i.i.imm == MRET_FUNCT12) begin
              ctrl_o.jalr    = `JALR_MEPC;
              ctrl_o.int_rst = 1'b1;
            end else begin
              ctrl_o.illegal = 1'b1;  // no ecall or ebreak.
            end
          end
          3'b001: begin
            ctrl_o.csr         = 1'b1;
            ctrl_o.csr_op[1:0] = 2'b01;
            ctrl_o.gpr_we      = 1'b1;
          end
          3'b010: begin
            ctrl_o.csr         = 1'b1;
            ctrl_o.csr_op[1:0] = 2'b11;
            ctrl_o.gpr_we      = 1'b1;
          end
          3'b011: begin
            ctrl_o.csr         = 1'b1;
            ctrl_o.csr_op[1:0] = 2'b10;
            ctrl_o.gpr_we      = 1'b1;
          end
          default: ctrl_o.illegal = 1'b1;
        endcase
      end

      default: ctrl_o.illegal = 1'b1;
    endcase

    // an illegal word has no side effects.
    if (ctrl_o.illegal) begin
      ctrl_o.gpr_we  = 1'b0;
      ctrl_o.branch  = 1'b0;
      ctrl_o.jal     = 1'b0;
      ctrl_o.jalr    = `JALR_NONE;
      ctrl_o.csr     = 1'b0;
      ctrl_o.int_rst = 1'b0;
      mem_o.req      = 1'b0;
      mem_o.we       = 1'b0;
    end

    if (int_i) begin
      ctrl_o.jalr = `JALR_MTVEC;
      mem_o.req   = 1'b0;
      mem_o.we    = 1'b0;
    end

    ctrl_o.csr_op[2] = int_i;
    ctrl_o.gpr_we    = ctrl_o.gpr_we & enpc_o & !int_i;
  end

endmodule

/* rtl/alu_riscv.sv */
`timescale 1ns/100ps
`include "riscv_macros.svh"

module alu_riscv (
  input  logic [4:0]  alu_op_i,
  input  logic [31:0] a_i,
  input  logic [31:0] b_i,
  output logic [31:0] result_o,
  output logic        flag_o
);
  logic [4:0] shamt;

  assign shamt = b_i[4:0];

  always_comb begin
    result_o = '0;
    flag_o   = 1'b0;
    case (alu_op_i)
      `ALU_ADD:  result_o = a_i + b_i;
      `ALU_SUB:  result_o = a_i - b_i;
      `ALU_SLL:  result_o = a_i << shamt;
      `ALU_SRL:  result_o = a_i >> shamt;
      `ALU_SRA:  result_o = $signed(a_i) >>> shamt;
      `ALU_SLTS: result_o = {31'b0, $signed(a_i) < $signed(b_i)};
      `ALU_SLTU: result_o = {31'b0, a_i < b_i};
      `ALU_XOR:  result_o = a_i ^ b_i;
      `ALU_OR:   result_o = a_i | b_i;
      `ALU_AND:  result_o = a_i & b_i;
      // compares only raise the flag.
      `ALU_EQ:   flag_o = (a_i == b_i);
      `ALU_NE:   flag_o = (a_i != b_i);
      `ALU_LTS:  flag_o = ($signed(a_i) < $signed(b_i));
      `ALU_GES:  flag_o = ($signed(a_i) >= $signed(b_i));
      `ALU_LTU:  flag_o = (a_i < b_i);
      `ALU_GEU:  flag_o = (a_i >= b_i);
      default: begin
        result_o = '0;
        flag_o   = 1'b0;
      end
    endcase
  end

endmodule

/* rtl/rf_riscv.sv */
`timescale 1ns/100ps
`include "riscv_macros.svh"

module rf_riscv (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  riscv_pkg::instr_u instr_i,
  input  logic              we_i,
  input  logic              wb_src_i,
  input  logic              csr_i,
  input  logic [31:0]       alu_res_i,
  input  logic [31:0]       lsu_data_i,
  input  logic [31:0]       csr_data_i,
  output logic [31:0]       rs1_o,
  output logic [31:0]       rs2_o
);
  logic [31:0] regs [1:31];
  logic [31:0] wd;

  // write-back select.
  assign wd = csr_i                      ? csr_data_i :
              (wb_src_i == `WB_LSU_DATA) ? lsu_data_i : alu_res_i;

  assign rs1_o = (instr_i.r.rs1 == 5'd0) ? '0 : regs[instr_i.r.rs1];
  assign rs2_o = (instr_i.r.rs2 == 5'd0) ? '0 : regs[instr_i.r.rs2];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int k = 1; k < 32; k++)
        regs[k] <= '0;
    end else if (we_i && instr_i.r.rd != 5'd0) begin
      regs[instr_i.r.rd] <= wd;
    end
  end

endmodule

/* rtl/csr_riscv.sv */
`timescale 1ns/100ps
`include "riscv_macros.svh"

module csr_riscv (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  riscv_pkg::instr_u instr_i,
  input  riscv_pkg::ctrl_t  ctrl_i,
  input  logic              en_i,
  input  logic [31:0]       rs1_i,
  input  logic [31:0]       pc_i,
  input  logic              int_req_i,
  output logic [31:0]       rd_o,
  output logic [31:0]       mtvec_o,
  output logic [31:0]       mepc_o,
  output logic              int_o
);
  logic [31:0] mstatus, mie, mtvec, mscratch, mepc, mcause;
  logic [31:0] wdata;
  logic [11:0] addr;
  logic        in_trap;

  assign addr    = instr_i.i.imm;
  assign mtvec_o = mtvec;
  assign mepc_o  = mepc;
  assign int_o   = int_req_i & mie[11] & mstatus[3] & !in_trap;  // meie and mie bits.

  always_comb begin
    case (addr)
      `CSR_MSTATUS:  rd_o = mstatus;
      `CSR_MIE:      rd_o = mie;
      `CSR_MTVEC:    rd_o = mtvec;
      `CSR_MSCRATCH: rd_o = mscratch;
      `CSR_MEPC:     rd_o = mepc;
      `CSR_MCAUSE:   rd_o = mcause;
      default:       rd_o = '0;
    endcase
  end

  always_comb begin
    case (ctrl_i.csr_op[1:0])
      2'b01:   wdata = rs1_i;          // csrrw.
      2'b11:   wdata = rd_o | rs1_i;   // csrrs.
      2'b10:   wdata = rd_o & ~rs1_i;  // csrrc.
      default: wdata = rd_o;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mstatus  <= '0;
      mie      <= '0;
      mtvec    <= '0;
      mscratch <= '0;
      mepc     <= '0;
      mcause   <= '0;
      in_trap  <= 1'b0;
    end else if (en_i) begin
      if (ctrl_i.csr_op[2]) begin
        mepc    <= pc_i;
        mcause  <= 32'h8000_000B;  // machine external interrupt.
        in_trap <= 1'b1;
      end else begin
        if (ctrl_i.int_rst)
          in_trap <= 1'b0;
        if (ctrl_i.csr) begin
          case (addr)
            `CSR_MSTATUS:  mstatus  <= wdata;
            `CSR_MIE:      mie      <= wdata;
            `CSR_MTVEC:    mtvec    <= wdata;
            `CSR_MSCRATCH: mscratch <= wdata;
            `CSR_MEPC:     mepc     <= wdata;
            `CSR_MCAUSE:   mcause   <= wdata;
            default: ;
          endcase
        end
      end
    end
  end

endmodule

/* rtl/pc_riscv.sv */
`timescale 1ns/100ps
`include "riscv_macros.svh"

module pc_riscv (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  riscv_pkg::instr_u instr_i,
  input  riscv_pkg::ctrl_t  ctrl_i,
  input  logic              enpc_i,
  input  logic              flag_i,
  input  logic [31:0]       rs1_i,
  input  logic [31:0]       rs2_i,
  input  logic [31:0]       mtvec_i,
  input  logic [31:0]       mepc_i,
  output logic [31:0]       pc_o,
  output logic [31:0]       op_a_o,
  output logic [31:0]       op_b_o
);
  logic [31:0] pc, pc_next, jalr_sum;
  logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;

  assign imm_i = {{20{instr_i.i.imm[11]}}, instr_i.i.imm};
  assign imm_s = {{20{instr_i.s.imm_hi[6]}}, instr_i.s.imm_hi, instr_i.s.imm_lo};
  assign imm_b = {{19{instr_i.b.imm12}}, instr_i.b.imm12, instr_i.b.imm11,
                  instr_i.b.imm10_5, instr_i.b.imm4_1, 1'b0};
  assign imm_u = {instr_i.u.imm, 12'b0};
  assign imm_j = {{11{instr_i.j.imm20}}, instr_i.j.imm20, instr_i.j.imm19_12,
                  instr_i.j.imm11, instr_i.j.imm10_1, 1'b0};

  assign pc_o     = pc;
  assign jalr_sum = rs1_i + imm_i;

  always_comb begin
    case (ctrl_i.ex_op_a_sel)
      `OP_A_CURR_PC: op_a_o = pc;
      `OP_A_ZERO:    op_a_o = '0;
      default:       op_a_o = rs1_i;
    endcase
    case (ctrl_i.ex_op_b_sel)
      `OP_B_IMM_I: op_b_o = imm_i;
      `OP_B_IMM_U: op_b_o = imm_u;
      `OP_B_IMM_S: op_b_o = imm_s;
      `OP_B_INCR:  op_b_o = 32'd4;
      default:     op_b_o = rs2_i;
    endcase
  end

  always_comb begin
    case (ctrl_i.jalr)
      `JALR_MTVEC: pc_next = mtvec_i;
      `JALR_MEPC:  pc_next = mepc_i;
      `JALR_ALU:   pc_next = {jalr_sum[31:1], 1'b0};
      default: begin
        if (ctrl_i.jal)
          pc_next = pc + imm_j;
        else if (ctrl_i.branch && flag_i)
          pc_next = pc + imm_b;
        else
          pc_next = pc + 32'd4;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i)
      pc <= '0;
    else if (enpc_i)
      pc <= pc_next;
  end

endmodule

/* rtl/lsu_riscv.sv */
`timescale 1ns/100ps
`include "riscv_macros.svh"

module lsu_riscv (
  input  riscv_pkg::mem_req_t mem_i,
  input  logic [31:0]         addr_i,
  input  logic [31:0]         wd_i,
  input  logic [31:0]         mem_rd_i,
  output logic                mem_req_o,
  output logic                mem_we_o,
  output logic [3:0]          mem_be_o,
  output logic [31:0]         mem_wd_o,
  output logic [31:0]         rd_o
);
  logic [7:0]  rd_byte;
  logic [15:0] rd_half;

  assign mem_req_o = mem_i.req;
  assign mem_we_o  = mem_i.we;

  assign rd_byte = mem_rd_i[8*addr_i[1:0] +: 8];
  assign rd_half = addr_i[1] ? mem_rd_i[31:16] : mem_rd_i[15:0];

  always_comb begin
    case (mem_i.size)
      `LDST_B, `LDST_BU: begin
        mem_wd_o = {4{wd_i[7:0]}};
        mem_be_o = 4'b0001 << addr_i[1:0];
      end
      `LDST_H, `LDST_HU: begin
        mem_wd_o = {2{wd_i[15:0]}};
        mem_be_o = addr_i[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        mem_wd_o = wd_i;
        mem_be_o = 4'b1111;
      end
    endcase
    if (!mem_i.req)
      mem_be_o = 4'b0000;
  end

  always_comb begin
    case (mem_i.size)
      `LDST_B:  rd_o = {{24{rd_byte[7]}}, rd_byte};
      `LDST_BU: rd_o = {24'b0, rd_byte};
      `LDST_H:  rd_o = {{16{rd_half[15]}}, rd_half};
      `LDST_HU: rd_o = {16'b0, rd_half};
      default:  rd_o = mem_rd_i;
    endcase
  end

endmodule

/* rtl/riscv_core.sv */
`timescale 1ns/100ps

module riscv_core (
  input  logic        clk_i,
  input  logic        rst_n_i,
  output logic [31:0] instr_addr_o,
  input  logic [31:0] instr_i,
  output logic        mem_req_o,
  output logic        mem_we_o,
  output logic [3:0]  mem_be_o,
  output logic [31:0] mem_addr_o,
  output logic [31:0] mem_wd_o,
  input  logic [31:0] mem_rd_i,
  input  logic        mem_stall_i,
  input  logic        int_i
);
  import riscv_pkg::*;

  ctrl_t       ctrl;
  mem_req_t    mem;
  logic        enpc, flag, int_take;
  logic [31:0] pc, op_a, op_b, alu_res;
  logic [31:0] rs1, rs2, lsu_data, csr_data, mtvec, mepc;

  assign instr_addr_o = pc;
  assign mem_addr_o   = alu_res;

  decoder_riscv u_decoder (
    .fetched_instr_i (instr_i),
    .lsu_stall_req_i (mem_stall_i),
    .int_i           (int_take),
    .ctrl_o          (ctrl),
    .mem_o           (mem),
    .enpc_o          (enpc)
  );

  pc_riscv u_pc (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .instr_i (instr_i),
    .ctrl_i  (ctrl),
    .enpc_i  (enpc),
    .flag_i  (flag),
    .rs1_i   (rs1),
    .rs2_i   (rs2),
    .mtvec_i (mtvec),
    .mepc_i  (mepc),
    .pc_o    (pc),
    .op_a_o  (op_a),
    .op_b_o  (op_b)
  );

  alu_riscv u_alu (
    .alu_op_i (ctrl.alu_op),
    .a_i      (op_a),
    .b_i      (op_b),
    .result_o (alu_res),
    .flag_o   (flag)
  );

  rf_riscv u_rf (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .instr_i    (instr_i),
    .we_i       (ctrl.gpr_we),
    .wb_src_i   (ctrl.wb_src_sel),
    .csr_i      (ctrl.csr),
    .alu_res_i  (alu_res),
    .lsu_data_i (lsu_data),
    .csr_data_i (csr_data),
    .rs1_o      (rs1),
    .rs2_o      (rs2)
  );

  csr_riscv u_csr (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .instr_i   (instr_i),
    .ctrl_i    (ctrl),
    .en_i      (enpc),
    .rs1_i     (rs1),
    .pc_i      (pc),
    .int_req_i (int_i),
    .rd_o      (csr_data),
    .mtvec_o   (mtvec),
    .mepc_o    (mepc),
    .int_o     (int_take)
  );

  lsu_riscv u_lsu (
    .mem_i     (mem),
    .addr_i    (alu_res),
    .wd_i      (rs2),
    .mem_rd_i  (mem_rd_i),
    .mem_req_o (mem_req_o),
    .mem_we_o  (mem_we_o),
    .mem_be_o  (mem_be_o),
    .mem_wd_o  (mem_wd_o),
    .rd_o      (lsu_data)
  );

endmodule

/* test/riscv_core_asserts.sv */
`timescale 1ns/100ps

module riscv_core_asserts (
  input logic        clk_i,
  input logic        rst_n_i,
  input logic [31:0] pc_i,
  input logic [31:0] instr_i,
  input logic        mem_req_i,
  input logic        mem_we_i,
  input logic [3:0]  mem_be_i,
  input logic [31:0] mem_addr_i,
  input logic        mem_stall_i,
  input logic        int_take_i,
  input logic [31:0] mtvec_i,
  input logic [31:0] mepc_i
);
  localparam logic [31:0] MRET_WORD = 32'h3020_0073;

  int err_cnt = 0;

  // pc frozen for the whole stall.
  stall_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_stall_i |=> $stable(pc_i))
    else begin
      err_cnt++;
      $error("pc moved while the memory stalled");
    end

  // a taken write moves on, so it is never repeated.
  single_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (mem_req_i && mem_we_i && !mem_stall_i) |=> $changed(pc_i))
    else begin
      err_cnt++;
      $error("the same store was taken twice");
    end

  // one lane per byte, the addressed half per halfword, all lanes per word.
  byte_enables: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_req_i |->
      (instr_i[13:12] == 2'b00 && $onehot(mem_be_i) && mem_be_i[mem_addr_i[1:0]]) ||
      (instr_i[13:12] == 2'b01 &&
       mem_be_i == {{2{mem_addr_i[1]}}, {2{!mem_addr_i[1]}}}) ||
      (instr_i[13:12] == 2'b10 && mem_be_i == 4'b1111))
    else begin
      err_cnt++;
      $error("byte enables do not match size and address");
    end

  trap_entry: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (int_take_i && !mem_stall_i) |=> (pc_i == $past(mtvec_i)))
    else begin
      err_cnt++;
      $error("interrupt did not jump to mtvec");
    end

  trap_return: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (instr_i == MRET_WORD && !int_take_i && !mem_stall_i) |=> (pc_i == $past(mepc_i)))
    else begin
      err_cnt++;
      $error("mret did not return to mepc");
    end

  // undefined opcode 7f.
  illegal_quiet: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (instr_i[6:0] == 7'h7F) |-> !mem_req_i)
    else begin
      err_cnt++;
      $error("illegal word made a memory request");
    end

endmodule

bind riscv_core riscv_core_asserts u_asserts (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .pc_i        (instr_addr_o),
  .instr_i     (instr_i),
  .mem_req_i   (mem_req_o),
  .mem_we_i    (mem_we_o),
  .mem_be_i    (mem_be_o),
  .mem_addr_i  (mem_addr_o),
  .mem_stall_i (mem_stall_i),
  .int_take_i  (int_take),
  .mtvec_i     (mtvec),
  .mepc_i      (mepc)
);

/* test/tb_riscv_core.sv */
`timescale 1ns/100ps

module tb_riscv_core;
  localparam logic [6:0] OPC_LOAD  = 7'b0000011;
  localparam logic [6:0] OPC_IMM   = 7'b0010011;
  localparam logic [6:0] OPC_AUIPC = 7'b0010111;
  localparam logic [6:0] OPC_STORE = 7'b0100011;
  localparam logic [6:0] OPC_OP    = 7'b0110011;
  localparam logic [6:0] OPC_LUI   = 7'b0110111;
  localparam logic [6:0] OPC_JALR  = 7'b1100111;
  localparam logic [6:0] OPC_SYS   = 7'b1110011;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  be;
  } store_t;

  logic        clk, rst_n, mem_stall, int_req;
  logic        mem_req, mem_we;
  logic [3:0]  mem_be;
  logic [31:0] instr_addr, instr, mem_addr, mem_wd, mem_rd;

  logic [31:0] rom [0:255];
  logic [31:0] dmem [0:255];
  store_t      exp_q[$];
  store_t      got;
  logic [31:0] at, slot, loop_pc, mark_pc;
  logic [1:0]  stall_left;
  integer      seed;
  int          n_instr, max_cycles, cycles, n;

  riscv_core dut (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .instr_addr_o (instr_addr),
    .instr_i      (instr),
    .mem_req_o    (mem_req),
    .mem_we_o     (mem_we),
    .mem_be_o     (mem_be),
    .mem_addr_o   (mem_addr),
    .mem_wd_o     (mem_wd),
    .mem_rd_i     (mem_rd),
    .mem_stall_i  (mem_stall),
    .int_i        (int_req)
  );

  // both memories answer within the cycle.
  assign instr  = rom[instr_addr[9:2]];
  assign mem_rd = dmem[mem_addr[9:2]];

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] i_word(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                         logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] r_word(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] s_word(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
  endfunction

  function automatic logic [31:0] b_word(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] j_word(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  task automatic put(input logic [31:0] w);
    rom[at[9:2]] = w;
    at = at + 32'd4;
    n_instr++;
  endtask

  // sw rs to the next result slot, and expect it there.
  task automatic store_word(input logic [4:0] rs, input logic [31:0] value);
    put(s_word(slot[11:0], rs, 5'd0, 3'b010));
    exp_q.push_back({slot, value, 4'b1111});
    slot = slot + 32'd4;
  endtask

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic wait_pc(input logic [31:0] target);
    @(negedge clk);
    while (instr_addr != target)
      @(negedge clk);
    @(posedge clk);
  endtask

  task automatic build_program();
    at = 0;
    slot = 32'h100;
    for (int k = 0; k < 256; k++) begin
      rom[k]  = 32'h0000_0013;  // nop.
      dmem[k] = k * 32'h9E37_79B1;
    end
    put(i_word(12'd5, 5'd0, 3'd0, 5'd1, OPC_IMM));
    put(i_word(-12'sd3, 5'd0, 3'd0, 5'd2, OPC_IMM));
    put(r_word(7'h00, 5'd2, 5'd1, 3'd0, 5'd3));
    store_word(5'd3, 32'd2);
    put(r_word(7'h20, 5'd2, 5'd1, 3'd0, 5'd4));
    store_word(5'd4, 32'd8);
    put(i_word(12'h401, 5'd2, 3'd5, 5'd5, OPC_IMM));  // srai by 1.
    store_word(5'd5, 32'hFFFF_FFFE);
    put(r_word(7'h00, 5'd2, 5'd1, 3'd4, 5'd6));
    store_word(5'd6, 32'hFFFF_FFF8);
    put(r_word(7'h00, 5'd2, 5'd1, 3'd3, 5'd7));
    store_word(5'd7, 32'd1);
    put({20'h12345, 5'd8, OPC_LUI});
    store_word(5'd8, 32'h1234_5000);
    mark_pc = at;
    put({20'h00001, 5'd9, OPC_AUIPC});
    store_word(5'd9, mark_pc + 32'h1000);

    // byte and halfword traffic at 0x300.
    put(i_word(12'h1A5, 5'd0, 3'd0, 5'd10, OPC_IMM));
    put(s_word(12'h301, 5'd10, 5'd0, 3'd0));
    exp_q.push_back({32'h301, {4{8'hA5}}, 4'b0010});
    put(i_word(12'h301, 5'd0, 3'd0, 5'd11, OPC_LOAD));
    store_word(5'd11, 32'hFFFF_FFA5);
    put(i_word(12'h301, 5'd0, 3'd4, 5'd12, OPC_LOAD));
    store_word(5'd12, 32'h0000_00A5);
    put(s_word(12'h306, 5'd2, 5'd0, 3'd1));
    exp_q.push_back({32'h306, {2{16'hFFFD}}, 4'b1100});
    put(i_word(12'h306, 5'd0, 3'd1, 5'd13, OPC_LOAD));
    store_word(5'd13, 32'hFFFF_FFFD);
    put(i_word(12'h306, 5'd0, 3'd5, 5'd14, OPC_LOAD));
    store_word(5'd14, 32'h0000_FFFD);

    // skipped stores go to 0x3f0 and must never show up.
    put(b_word(13'd8, 5'd1, 5'd1, 3'd0));
    put(s_word(12'h3F0, 5'd0, 5'd0, 3'd2));
    put(b_word(13'd8, 5'd1, 5'd1, 3'd1));
    store_word(5'd1, 32'd5);
    put(b_word(13'd8, 5'd1, 5'd2, 3'd4));
    put(s_word(12'h3F0, 5'd0, 5'd0, 3'd2));
    put(b_word(13'd8, 5'd2, 5'd1, 3'd7));
    store_word(5'd3, 32'd2);
    mark_pc = at;
    put(j_word(21'd8, 5'd15));
    put(s_word(12'h3F0, 5'd0, 5'd0, 3'd2));
    store_word(5'd15, mark_pc + 32'd4);
    mark_pc = at;
    put({20'h0, 5'd16, OPC_AUIPC});
    put(i_word(12'd12, 5'd16, 3'd0, 5'd17, OPC_JALR));
    put(s_word(12'h3F0, 5'd0, 5'd0, 3'd2));
    store_word(5'd17, mark_pc + 32'd8);

    // undefined opcode naming x18 as rd.
    put(i_word(12'd77, 5'd0, 3'd0, 5'd18, OPC_IMM));
    put({20'h0, 5'd18, 7'h7F});
    store_word(5'd18, 32'd77);

    put(i_word(12'h200, 5'd0, 3'd0, 5'd20, OPC_IMM));
    put(i_word(12'h305, 5'd20, 3'd1, 5'd0, OPC_SYS));  // mtvec.
    put(i_word(12'd1, 5'd0, 3'd0, 5'd21, OPC_IMM));
    put(i_word(12'd11, 5'd21, 3'd1, 5'd21, OPC_IMM));
    put(i_word(12'h304, 5'd21, 3'd2, 5'd0, OPC_SYS));  // meie.
    put(i_word(12'd8, 5'd0, 3'd0, 5'd22, OPC_IMM));
    put(i_word(12'h300, 5'd22, 3'd2, 5'd0, OPC_SYS));
    put(i_word(12'h340, 5'd1, 3'd1, 5'd23, OPC_SYS));
    put(i_word(12'h340, 5'd0, 3'd2, 5'd24, OPC_SYS));
    store_word(5'd23, 32'd0);
    store_word(5'd24, 32'd5);
    put(i_word(12'h340, 5'd1, 3'd3, 5'd0, OPC_SYS));
    put(i_word(12'h340, 5'd0, 3'd2, 5'd27, OPC_SYS));
    store_word(5'd27, 32'd0);
    loop_pc = at;
    put(j_word(21'd0, 5'd0));

    // interrupt handler.
    at = 32'h200;
    put(i_word(12'h342, 5'd0, 3'd2, 5'd25, OPC_SYS));
    store_word(5'd25, 32'h8000_000B);
    put(i_word(12'h341, 5'd0, 3'd2, 5'd26, OPC_SYS));
    store_word(5'd26, loop_pc);
    put(32'h3020_0073);  // mret.
  endtask

  // each cycle draws 0 to 2 stall cycles for the next access.
  always @(posedge clk) begin
    if (rst_n) begin
      if (mem_stall) begin
        if (stall_left == 2'd0)
          mem_stall <= 1'b0;
        else
          stall_left <= stall_left - 2'd1;
      end else begin
        n = $unsigned($random(seed)) % 3;
        if (n != 0) begin
          mem_stall  <= 1'b1;
          stall_left <= n - 1;
        end
      end
    end
  end

  // a store is taken at the next edge, so look at it mid-cycle.
  always @(negedge clk) begin
    if (rst_n && mem_req && mem_we && !mem_stall) begin
      if (exp_q.size() == 0) begin
        fail_now("an unexpected store reached the data memory");
      end else begin
        got = exp_q.pop_front();
        assert (mem_addr == got.addr && mem_wd == got.data && mem_be == got.be)
          else fail_now($sformatf("Fail at %0t: store %h/%h/%b, expected %h/%h/%b",
                                  $time, mem_addr, mem_wd, mem_be,
                                  got.addr, got.data, got.be));
        for (int b = 0; b < 4; b++)
          if (mem_be[b])
            dmem[mem_addr[9:2]][8*b +: 8] <= mem_wd[8*b +: 8];
      end
    end
  end

  always @(dut.u_asserts.err_cnt) begin
    if (dut.u_asserts.err_cnt != 0)
      fail_now("a bound assertion on the core failed");
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > max_cycles)
      fail_now("timeout, the program did not finish in time");
  end

  initial begin
    seed       = 6898;
    rst_n      = 1'b0;
    mem_stall  = 1'b0;
    int_req    = 1'b0;
    stall_left = 2'd0;
    cycles     = 0;
    n_instr    = 0;
    max_cycles = 100000;
    build_program();
    max_cycles = 4 * n_instr + 2 * n_instr + 100;  // two stall cycles at most each.
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    wait_pc(loop_pc);
    int_req <= 1'b1;
    wait_pc(32'h200);
    int_req <= 1'b0;
    wait_pc(loop_pc);

    if (exp_q.size() == 0) begin
      $display("ALL CHECKS PASSED");
      $finish;
    end else begin
      fail_now($sformatf("%0d expected stores never happened", exp_q.size()));
    end
  end

endmodule

/* files.f */
+incdir+rtl
rtl/riscv_pkg.sv
rtl/decoder_riscv.sv
rtl/alu_riscv.sv
rtl/rf_riscv.sv
rtl/csr_riscv.sv
rtl/pc_riscv.sv
rtl/lsu_riscv.sv
rtl/riscv_core.sv
test/riscv_core_asserts.sv
test/tb_riscv_core.sv
